/* hw/stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  // SPI word and header layout
  localparam int word_w = 64;
  localparam int cmd_w = 8;

  // Width of the duration, increment and increment-of-increment fields
  localparam int field_w = 32;

  // Configuration register widths
  localparam int microsteps_w = 3;
  localparam int current_w = 8;
  localparam int clk_div_w = 8;

  // Saturating dropped-move counter
  localparam int drop_w = 8;

  // Command codes in the top byte of the header word
  localparam logic [cmd_w-1:0] cmd_move = 8'h01;
  localparam logic [cmd_w-1:0] cmd_enable = 8'h0A;
  localparam logic [cmd_w-1:0] cmd_clk_div = 8'h0B;
  localparam logic [cmd_w-1:0] cmd_motor_cfg = 8'h10;
  localparam logic [cmd_w-1:0] cmd_status = 8'h16;
  localparam logic [cmd_w-1:0] cmd_version = 8'hFE;

  // Header plus three data words
  localparam int move_words = 4;

  // API version reported by cmd_version
  localparam logic [7:0] version_major = 8'd0;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd1;

  // Power-up configuration
  localparam logic [microsteps_w-1:0] microsteps_reset = 3'd2;
  localparam logic [current_w-1:0] current_reset = 8'd140;
  localparam logic [clk_div_w-1:0] clk_div_reset = 8'd40;

endpackage

`default_nettype wire

/* hw/spi_word_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_word_rx (
  input  logic CLK,
  input  logic rst,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic [stepper_pkg::word_w-1:0] tx_word,
  output logic [stepper_pkg::word_w-1:0] rx_word,
  output logic rx_valid
);

  // Room to count one bit past a full word
  localparam int CNT_W = $clog2(stepper_pkg::word_w + 2);

  // Two sync stages plus one history flop for edge detect
  logic [2:0] sck_s;
  logic [2:0] cs_s;
  // COPI only needs to line up with sck_s[1]
  logic [1:0] copi_s;

  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic cs_active;

  logic [CNT_W-1:0] bit_cnt;
  logic [stepper_pkg::word_w-1:0] rx_shift;
  logic [stepper_pkg::word_w-1:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_s <= '0;
      // Bus idles with CS high
      cs_s <= '1;
      copi_s <= '0;
    end else begin
      sck_s <= {sck_s[1:0], SCK};
      cs_s <= {cs_s[1:0], CS};
      copi_s <= {copi_s[0], COPI};
    end
  end

  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign cs_rise = cs_s[1] & ~cs_s[2];
  assign cs_fall = ~cs_s[1] & cs_s[2];
  assign cs_active = ~cs_s[1];

  // Bit counter saturates so long frames never look complete
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_rise && (bit_cnt == CNT_W'(stepper_pkg::word_w));
      if (cs_fall) begin
        bit_cnt <= '0;
      end else if (cs_active && sck_rise && (bit_cnt != '1)) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Mode 0 capture with the MSB first
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[stepper_pkg::word_w-2:0], copi_s[1]};
    end
  end

  // Stable from CS rise until the next frame clocks in
  assign rx_word = rx_shift;

  // Reply word loaded at frame start and advanced on SCK falling
  always_ff @(posedge CLK) begin
    if (rst) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= tx_word;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[stepper_pkg::word_w-2:0], 1'b0};
    end
  end

  assign CIPO = tx_shift[stepper_pkg::word_w-1];

endmodule

`default_nettype wire

/* hw/cmd_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic CLK,
  input  logic rst,
  input  logic [stepper_pkg::word_w-1:0] rx_word,
  input  logic rx_valid,
  input  logic [stepper_pkg::word_w-1:0] encoder_count,
  output logic [stepper_pkg::word_w-1:0] tx_word,
  output logic enable,
  output logic [stepper_pkg::microsteps_w-1:0] microsteps,
  output logic [stepper_pkg::current_w-1:0] current,
  output logic [stepper_pkg::clk_div_w-1:0] clk_div,
  output logic push,
  output logic push_dir,
  output logic [stepper_pkg::field_w-1:0] push_duration,
  output logic [stepper_pkg::field_w-1:0] push_increment,
  output logic [stepper_pkg::field_w-1:0] push_incinc,
  input  logic move_done,
  output logic buffer_ready
);

  // Credit counter holds 0..QUEUE_DEPTH
  localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

  logic [CREDIT_W-1:0] credits;
  logic [stepper_pkg::drop_w-1:0] drop_count;

  // Set after a move header and cleared after its last data word
  logic in_move;
  // Index of the expected data word from 1 to 3
  logic [1:0] word_idx;

  logic [stepper_pkg::cmd_w-1:0] header_cmd;
  logic [stepper_pkg::word_w-1:0] encoder_snap;
  logic [stepper_pkg::word_w-1:0] status_word;
  logic [stepper_pkg::word_w-1:0] version_word;
  logic last_word;
  logic take_credit;

  assign header_cmd = rx_word[stepper_pkg::word_w-1 -: stepper_pkg::cmd_w];
  assign last_word = in_move && (word_idx == 2'(stepper_pkg::move_words - 1));
  assign take_credit = rx_valid && last_word && (credits != '0);
  assign buffer_ready = (credits != '0);

  always_comb begin
    status_word = '0;
    status_word[7:0] = 8'(credits);
    status_word[23:16] = drop_count;
  end

  always_comb begin
    version_word = '0;
    version_word[23:16] = stepper_pkg::version_major;
    version_word[15:8] = stepper_pkg::version_minor;
    version_word[7:0] = stepper_pkg::version_patch;
  end

  // Single-word configuration commands
  always_ff @(posedge CLK) begin
    if (rst) begin
      enable <= 1'b0;
      microsteps <= stepper_pkg::microsteps_reset;
      current <= stepper_pkg::current_reset;
      clk_div <= stepper_pkg::clk_div_reset;
    end else if (rx_valid && !in_move) begin
      case (header_cmd)
        stepper_pkg::cmd_enable: enable <= rx_word[0];
        stepper_pkg::cmd_clk_div: clk_div <= rx_word[7:0];
        stepper_pkg::cmd_motor_cfg: begin
          microsteps <= rx_word[2:0];
          current <= rx_word[15:8];
        end
        default: ;
      endcase
    end
  end

  // Move message sequencing and the push strobe
  always_ff @(posedge CLK) begin
    if (rst) begin
      in_move <= 1'b0;
      word_idx <= '0;
      push <= 1'b0;
    end else begin
      push <= take_credit;
      if (rx_valid) begin
        if (!in_move) begin
          if (header_cmd == stepper_pkg::cmd_move) begin
            in_move <= 1'b1;
            word_idx <= 2'd1;
          end
        end else if (last_word) begin
          in_move <= 1'b0;
          word_idx <= '0;
        end else begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  // Move fields collected word by word and held for the queue write
  always_ff @(posedge CLK) begin
    if (rx_valid) begin
      if (!in_move && (header_cmd == stepper_pkg::cmd_move)) begin
        push_dir <= rx_word[0];
        // Encoder position at the moment the move was requested
        encoder_snap <= encoder_count;
      end else if (in_move) begin
        case (word_idx)
          2'd1: push_duration <= rx_word[stepper_pkg::field_w-1:0];
          2'd2: push_increment <= rx_word[stepper_pkg::field_w-1:0];
          default: push_incinc <= rx_word[stepper_pkg::field_w-1:0];
        endcase
      end
    end
  end

  // Credits are spent on push and returned on move_done
  always_ff @(posedge CLK) begin
    if (rst) begin
      credits <= CREDIT_W'(QUEUE_DEPTH);
      drop_count <= '0;
    end else begin
      credits <= credits - CREDIT_W'(take_credit) + CREDIT_W'(move_done);
      // Move completed with no credit left
      if (rx_valid && last_word && (credits == '0) && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  // Reply for the following frame
  always_ff @(posedge CLK) begin
    if (rst) begin
      tx_word <= '0;
    end else if (rx_valid) begin
      if (in_move) begin
        // Snapshot goes out during the third data word
        tx_word <= (word_idx == 2'd2) ? encoder_snap : '0;
      end else begin
        case (header_cmd)
          stepper_pkg::cmd_version: tx_word <= version_word;
          stepper_pkg::cmd_status: tx_word <= status_word;
          default: tx_word <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hw/move_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module move_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic CLK,
  input  logic rst,
  input  logic push,
  input  logic push_dir,
  input  logic [stepper_pkg::field_w-1:0] push_duration,
  input  logic [stepper_pkg::field_w-1:0] push_increment,
  input  logic [stepper_pkg::field_w-1:0] push_incinc,
  input  logic pop,
  output logic head_valid,
  output logic head_dir,
  output logic [stepper_pkg::field_w-1:0] head_duration,
  output logic [stepper_pkg::field_w-1:0] head_increment,
  output logic [stepper_pkg::field_w-1:0] head_incinc
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Slot storage with one array per field
  logic dir_mem [QUEUE_DEPTH];
  logic [stepper_pkg::field_w-1:0] dur_mem [QUEUE_DEPTH];
  logic [stepper_pkg::field_w-1:0] inc_mem [QUEUE_DEPTH];
  logic [stepper_pkg::field_w-1:0] incinc_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Credits upstream keep push off a full queue
  always_ff @(posedge CLK) begin
    if (push) begin
      dir_mem[wr_ptr] <= push_dir;
      dur_mem[wr_ptr] <= push_duration;
      inc_mem[wr_ptr] <= push_increment;
      incinc_mem[wr_ptr] <= push_incinc;
    end
  end

  // Indexes wrap by compare so depth need not be a power of two
  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Head stays put until the step generator pops it
  assign head_valid = (count != '0);
  assign head_dir = dir_mem[rd_ptr];
  assign head_duration = dur_mem[rd_ptr];
  assign head_increment = inc_mem[rd_ptr];
  assign head_incinc = incinc_mem[rd_ptr];

endmodule

`default_nettype wire

/* hw/dda_stepper.sv */
`timescale 1ns/10ps
`default_nettype none

module dda_stepper (
  input  logic CLK,
  input  logic rst,
  input  logic [stepper_pkg::clk_div_w-1:0] clk_div,
  input  logic head_valid,
  input  logic head_dir,
  input  logic [stepper_pkg::field_w-1:0] head_duration,
  input  logic [stepper_pkg::field_w-1:0] head_increment,
  input  logic [stepper_pkg::field_w-1:0] head_incinc,
  output logic pop,
  output logic step,
  output logic dir
);

  localparam int FW = stepper_pkg::field_w;
  localparam int DW = stepper_pkg::clk_div_w;

  logic active;
  logic start;
  logic tick;

  // Tick divider with one spare bit for the compare
  logic [DW-1:0] div_cnt;
  logic [DW:0] div_next;

  // Fractional position and current rate
  logic [FW-1:0] acc;
  logic [FW-1:0] inc;
  logic [FW:0] acc_sum;
  logic [FW-1:0] tick_cnt;
  logic [FW-1:0] tick_next;

  // Hold off while a pop is still in flight to the queue
  assign start = head_valid && !active && !pop;

  // Divisor of 0 behaves as 1
  assign div_next = {1'b0, div_cnt} + 1'b1;
  assign tick = active && (div_next >= {1'b0, clk_div});

  // Carry out of the accumulator is a step
  assign acc_sum = {1'b0, acc} + {1'b0, inc};
  assign tick_next = tick_cnt + 1'b1;

  always_ff @(posedge CLK) begin
    if (rst) begin
      active <= 1'b0;
      pop <= 1'b0;
      step <= 1'b0;
      dir <= 1'b0;
      div_cnt <= '0;
      tick_cnt <= '0;
    end else begin
      pop <= 1'b0;
      step <= 1'b0;
      if (start) begin
        active <= 1'b1;
        dir <= head_dir;
        div_cnt <= '0;
        tick_cnt <= '0;
      end else if (tick) begin
        div_cnt <= '0;
        step <= acc_sum[FW];
        tick_cnt <= tick_next;
        // Last tick of the move frees the slot
        if (tick_next >= head_duration) begin
          active <= 1'b0;
          pop <= 1'b1;
        end
      end else if (active) begin
        div_cnt <= div_next[DW-1:0];
      end
    end
  end

  // Accumulator restarts from zero for each move
  always_ff @(posedge CLK) begin
    if (start) begin
      acc <= '0;
      inc <= head_increment;
    end else if (tick) begin
      acc <= acc_sum[FW-1:0];
      // Rate ramps once per tick
      inc <= inc + head_incinc;
    end
  end

endmodule

`default_nettype wire

/* hw/stepper_spi_top.sv */
`timescale 1ns/10ps
`default_nettype none

module stepper_spi_top #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic CLK,
  input  logic rst,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  input  logic [stepper_pkg::word_w-1:0] encoder_count,
  output logic step,
  output logic dir,
  output logic enable,
  output logic [stepper_pkg::microsteps_w-1:0] microsteps,
  output logic [stepper_pkg::current_w-1:0] current,
  output logic buffer_ready
);

  // SPI word path
  logic [stepper_pkg::word_w-1:0] rx_word;
  logic [stepper_pkg::word_w-1:0] tx_word;
  logic rx_valid;

  // Divisor from decoder to step generator
  logic [stepper_pkg::clk_div_w-1:0] clk_div;

  // Decoder to queue
  logic push;
  logic push_dir;
  logic [stepper_pkg::field_w-1:0] push_duration;
  logic [stepper_pkg::field_w-1:0] push_increment;
  logic [stepper_pkg::field_w-1:0] push_incinc;

  // Queue head to step generator
  logic head_valid;
  logic head_dir;
  logic [stepper_pkg::field_w-1:0] head_duration;
  logic [stepper_pkg::field_w-1:0] head_increment;
  logic [stepper_pkg::field_w-1:0] head_incinc;

  // Also the credit return
  logic pop;

  spi_word_rx u_rx (
    .CLK(CLK), .rst(rst), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .tx_word(tx_word), .rx_word(rx_word), .rx_valid(rx_valid)
  );

  cmd_decoder #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dec (
    .CLK(CLK), .rst(rst), .rx_word(rx_word), .rx_valid(rx_valid),
    .encoder_count(encoder_count), .tx_word(tx_word), .enable(enable),
    .microsteps(microsteps), .current(current), .clk_div(clk_div),
    .push(push), .push_dir(push_dir), .push_duration(push_duration),
    .push_increment(push_increment), .push_incinc(push_incinc),
    .move_done(pop), .buffer_ready(buffer_ready)
  );

  move_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .CLK(CLK), .rst(rst), .push(push), .push_dir(push_dir),
    .push_duration(push_duration), .push_increment(push_increment),
    .push_incinc(push_incinc), .pop(pop), .head_valid(head_valid),
    .head_dir(head_dir), .head_duration(head_duration),
    .head_increment(head_increment), .head_incinc(head_incinc)
  );

  dda_stepper u_dda (
    .CLK(CLK), .rst(rst), .clk_div(clk_div), .head_valid(head_valid),
    .head_dir(head_dir), .head_duration(head_duration),
    .head_increment(head_increment), .head_incinc(head_incinc),
    .pop(pop), .step(step), .dir(dir)
  );

endmodule

`default_nettype wire

/* testbench/tb_stepper_spi.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_stepper_spi;

  logic CLK;
  logic rst;
  logic SCK;
  logic CS;
  logic COPI;
  logic CIPO;
  logic [63:0] encoder_count;
  logic step;
  logic dir;
  logic enable;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic buffer_ready;

  // Random stream for durations and encoder values
  int seed;
  int step_count;
  int start_count;
  int n;
  int r;
  logic [63:0] reply;
  // Direction expected on every step while dir_check is set
  logic exp_dir;
  logic dir_check;

  stepper_spi_top #(.QUEUE_DEPTH(4)) dut (
    .CLK(CLK), .rst(rst), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .encoder_count(encoder_count), .step(step), .dir(dir), .enable(enable),
    .microsteps(microsteps), .current(current), .buffer_ready(buffer_ready)
  );

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic report_mismatch(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopping on first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "stopping on timeout");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else report_mismatch($sformatf("%s is %0h, expected %0h", what, got, exp));
  endtask

  // Steps only show up as single-cycle pulses
  assert property (@(posedge CLK) disable iff (rst) step |=> !step)
    else report_mismatch("step stayed high for more than one cycle");

  // dir must match the header bit of the running move
  assert property (@(posedge CLK) disable iff (rst) (step && dir_check) |-> (dir == exp_dir))
    else report_mismatch("dir differs from the move header bit during a step");

  // One falling edge sees each single-cycle step pulse
  always @(negedge CLK) begin
    if (rst) begin
      step_count <= 0;
    end else if (step) begin
      step_count <= step_count + 1;
    end
  end

  // One mode 0 frame sent MSB first with an SCK half-period of 4 clocks
  task automatic spi_frame(input logic [63:0] tx, output logic [63:0] rx);
    rx = '0;
    repeat (4) @(negedge CLK);
    CS = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      COPI = tx[i];
      repeat (4) @(negedge CLK);
      // Host samples CIPO as SCK rises
      rx = {rx[62:0], CIPO};
      SCK = 1'b1;
      repeat (4) @(negedge CLK);
      SCK = 1'b0;
    end
    repeat (4) @(negedge CLK);
    // Returns right at the CS rising edge
    CS = 1'b1;
    COPI = 1'b0;
  endtask

  // Status request plus a dummy frame that carries the answer
  task automatic read_status(output logic [63:0] status);
    logic [63:0] unused_reply;
    spi_frame({stepper_pkg::cmd_status, 56'd0}, unused_reply);
    spi_frame(64'd0, status);
  endtask

  // Header and three data words with the snapshot checked on the last one
  task automatic send_move(input logic dir_bit, input logic [31:0] duration,
                           input logic [31:0] increment, input logic [31:0] incinc);
    logic [63:0] frame_reply;
    logic [63:0] snap;
    snap = {$random(seed), $random(seed)};
    encoder_count = snap;
    spi_frame({stepper_pkg::cmd_move, 55'd0, dir_bit}, frame_reply);
    // Decoder samples the encoder a few clocks after CS rises
    repeat (4) @(negedge CLK);
    encoder_count = {$random(seed), $random(seed)};
    spi_frame({32'd0, duration}, frame_reply);
    spi_frame({32'd0, increment}, frame_reply);
    spi_frame({32'd0, incinc}, frame_reply);
    check_value("encoder snapshot reply", frame_reply, snap);
  endtask

  // Move completion is the internal pop strobe
  task automatic wait_move_done(input int limit);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (dut.pop !== 1'b1) begin
      cycles++;
      if (cycles > limit) begin
        report_timeout("the end of a move");
      end
      @(negedge CLK);
    end
  endtask

  task automatic wait_buffer_ready(input int limit);
    int cycles;
    cycles = 0;
    while (buffer_ready !== 1'b1) begin
      cycles++;
      if (cycles > limit) begin
        report_timeout("buffer_ready to rise");
      end
      @(negedge CLK);
    end
  endtask

  initial begin
    seed = 32'h428c_f3dd;
    rst = 1'b1;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    encoder_count = '0;
    exp_dir = 1'b0;
    dir_check = 1'b0;
    repeat (16) @(negedge CLK);
    rst = 1'b0;

    // Power-up values
    check_value("enable after reset", 64'(enable), 64'd0);
    check_value("microsteps after reset", 64'(microsteps), 64'd2);
    check_value("current after reset", 64'(current), 64'd140);
    check_value("buffer_ready after reset", 64'(buffer_ready), 64'd1);

    // Version reply lands in the following frame
    spi_frame({stepper_pkg::cmd_version, 56'd0}, reply);
    spi_frame(64'd0, reply);
    check_value("version reply", 64'(reply[23:0]),
                64'({stepper_pkg::version_major, stepper_pkg::version_minor,
                     stepper_pkg::version_patch}));

    // Config registers update 4 clocks after CS rises
    spi_frame({stepper_pkg::cmd_enable, 55'd0, 1'b1}, reply);
    repeat (4) @(negedge CLK);
    check_value("enable", 64'(enable), 64'd1);
    spi_frame({stepper_pkg::cmd_motor_cfg, 40'd0, 8'h5A, 5'd0, 3'd5}, reply);
    repeat (4) @(negedge CLK);
    check_value("microsteps", 64'(microsteps), 64'd5);
    check_value("current", 64'(current), 64'h5A);

    // Half-rate DDA moves at divisor 2
    spi_frame({stepper_pkg::cmd_clk_div, 48'd0, 8'd2}, reply);
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      n = 8 + (((r % 33) + 33) % 33);
      exp_dir = (i % 2 == 0);
      dir_check = 1'b1;
      start_count = step_count;
      send_move(exp_dir, 32'(n), 32'h8000_0000, 32'd0);
      wait_move_done(1000);
      check_value("dir at end of move", 64'(dir), 64'(exp_dir));
      // Let the counter take the final step
      @(negedge CLK);
      check_value("step count", 64'(step_count - start_count), 64'(n / 2));
      dir_check = 1'b0;
    end
    read_status(reply);
    check_value("drop count after moves", 64'(reply[23:16]), 64'd0);
    check_value("credits after moves", 64'(reply[7:0]), 64'd4);

    // Long first move keeps the queue occupied
    spi_frame({stepper_pkg::cmd_clk_div, 48'd0, 8'd200}, reply);
    for (int i = 0; i < 4; i++) begin
      send_move(1'b1, (i == 0) ? 32'd250 : 32'd2, 32'd0, 32'd0);
      repeat (4) @(negedge CLK);
      check_value("buffer_ready while filling", 64'(buffer_ready), 64'(i < 3));
    end
    // No credit left so this one is dropped
    send_move(1'b0, 32'd2, 32'd0, 32'd0);
    read_status(reply);
    check_value("credits when full", 64'(reply[7:0]), 64'd0);
    check_value("drop count when full", 64'(reply[23:16]), 64'd1);

    // Drain all four queued moves
    for (int i = 0; i < 4; i++) begin
      wait_move_done(60000);
    end
    wait_buffer_ready(10);
    read_status(reply);
    check_value("credits after drain", 64'(reply[7:0]), 64'd4);
    check_value("drop count after drain", 64'(reply[23:16]), 64'd1);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hw/stepper_pkg.sv
hw/spi_word_rx.sv
hw/cmd_decoder.sv
hw/move_queue.sv
hw/dda_stepper.sv
hw/stepper_spi_top.sv
testbench/tb_stepper_spi.sv

/* run.sh */
#!/bin/sh
# Build the stepper testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_stepper_spi \
  -f files.f -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
